// File: src/isaPkg.sv
/*
   Instruction-level definitions for the execute stage
   - instruction word type
   - ALU operation codes
   - branch condition codes
*/
`default_nettype none

package isaPkg;

   typedef logic [15:0] instrT;
   typedef logic [2:0]  aluOpT;
   typedef logic [1:0]  brCondT;

   // Shifts and rotates occupy the lower half of the opcode space
   localparam aluOpT opRll = 3'b000;
   localparam aluOpT opSll = 3'b001;
   localparam aluOpT opRor = 3'b010;
   localparam aluOpT opSrl = 3'b011;
   localparam aluOpT opAdd = 3'b100;
   localparam aluOpT opOr  = 3'b101;
   localparam aluOpT opXor = 3'b110;
   localparam aluOpT opAnd = 3'b111;

   // Condition field sits in instruction bits 12 to 11
   localparam brCondT brEqz = 2'b00;
   localparam brCondT brNez = 2'b01;
   localparam brCondT brLtz = 2'b10;
   localparam brCondT brGez = 2'b11;

endpackage

`default_nettype wire

// File: src/execPkg.sv
/*
   Datapath definitions for the execute stage
   - data and address word type
   - shift amount type
   - lookahead group width of the adder
*/
`default_nettype none

package execPkg;

   typedef logic [15:0] wordT;

   // Only the low bits of operand B reach the shifter
   typedef logic [3:0] shamtT;

   localparam int groupWidth = 4;

endpackage

`default_nettype wire

// File: src/claAdder.sv
/*
   Carry-lookahead adder of parameterized width
   - 4-bit lookahead groups with group propagate and generate
   - second lookahead level for the group carries
*/
`default_nettype none

module claAdder #(
   parameter int WIDTH = 16
) (
   input  wire [WIDTH-1:0] a,
   input  wire [WIDTH-1:0] b,
   input  wire             cin,
   output logic [WIDTH-1:0] sum,
   output logic             cout
);
   import execPkg::*;

   localparam int numGroups = WIDTH / groupWidth;

   wire  [WIDTH-1:0]     p;
   wire  [WIDTH-1:0]     g;
   wire  [WIDTH-1:0]     carry;
   wire  [numGroups-1:0] groupP;
   wire  [numGroups-1:0] groupG;
   logic [numGroups:0]   groupCarry;

   if (WIDTH % groupWidth != 0) begin : gWidthCheck
      $error("claAdder: WIDTH %0d is not a multiple of %0d", WIDTH, groupWidth);
   end

   assign p = a ^ b;
   assign g = a & b;

   for (genvar k = 0; k < numGroups; k++) begin : gGroup
      localparam int lo = k * groupWidth;

      logic [groupWidth-1:0] bp;
      logic [groupWidth-1:0] bg;
      logic                  cIn;

      assign bp  = p[lo +: groupWidth];
      assign bg  = g[lo +: groupWidth];
      assign cIn = groupCarry[k];

      // Bit carries inside the group all derive from the group carry-in
      assign carry[lo]   = cIn;
      assign carry[lo+1] = bg[0] | (bp[0] & cIn);
      assign carry[lo+2] = bg[1] | (bp[1] & bg[0]) | (bp[1] & bp[0] & cIn);
      assign carry[lo+3] = bg[2] | (bp[2] & bg[1]) | (bp[2] & bp[1] & bg[0])
                         | (bp[2] & bp[1] & bp[0] & cIn);

      assign groupP[k] = &bp;
      assign groupG[k] = bg[3] | (bp[3] & bg[2]) | (bp[3] & bp[2] & bg[1])
                       | (bp[3] & bp[2] & bp[1] & bg[0]);
   end

   // Each group carry expands from cin over the lower groups' P and G
   always_comb begin
      logic carryAcc;
      groupCarry[0] = cin;
      for (int k = 0; k < numGroups; k++) begin
         carryAcc = cin;
         for (int j = 0; j <= k; j++) begin
            carryAcc = groupG[j] | (groupP[j] & carryAcc);
         end
         groupCarry[k+1] = carryAcc;
      end
   end

   assign sum  = p ^ carry;
   assign cout = groupCarry[numGroups];

endmodule

`default_nettype wire

// File: src/alu.sv
/*
   ALU of the execute stage
   - rotate and shift, add, or, xor, and
   - optional inversion of either operand
   - zero and signed overflow flags
*/
`default_nettype none

module alu #(
   parameter int WIDTH = 16
) (
   input  wire execPkg::wordT inA,
   input  wire execPkg::wordT inB,
   input  wire isaPkg::aluOpT op,
   input  wire                invA,
   input  wire                invB,
   output execPkg::wordT      aluOut,
   output execPkg::wordT      addSum,
   output logic               cout,
   output logic               zero,
   output logic               ofl
);
   import isaPkg::*;
   import execPkg::*;

   localparam int w   = $bits(wordT);
   localparam int msb = w - 1;

   wordT              opA;
   wordT              opB;
   shamtT             shamt;
   logic [2*w-1:0]    rotL;
   logic [2*w-1:0]    rotR;

   assign opA   = invA ? ~inA : inA;
   assign opB   = invB ? ~inB : inB;
   assign shamt = opB[$bits(shamtT)-1:0];

   // Rotates shift a doubled copy and keep one half
   assign rotL = {opA, opA} << shamt;
   assign rotR = {opA, opA} >> shamt;

   // Carry-in completes the two's complement when one side is inverted
   claAdder #(
      .WIDTH(WIDTH)
   ) iAdder (
      .a   (opA),
      .b   (opB),
      .cin (invA | invB),
      .sum (addSum),
      .cout(cout)
   );

   always_comb begin
      case (op)
         opRll:   aluOut = rotL[2*w-1 -: w];
         opSll:   aluOut = opA << shamt;
         opRor:   aluOut = rotR[msb:0];
         opSrl:   aluOut = opA >> shamt;
         opAdd:   aluOut = addSum;
         opOr:    aluOut = opA | opB;
         opXor:   aluOut = opA ^ opB;
         opAnd:   aluOut = opA & opB;
         default: aluOut = '0;
      endcase
   end

   assign zero = (aluOut == '0);

   // Same operand signs with a different sum sign
   assign ofl = (opA[msb] == opB[msb]) && (addSum[msb] != opA[msb]);

   // Known operands with an unknown opcode means decode left the op floating
   always_comb begin
      if (!$isunknown({inA, inB})) begin
         assert final (!$isunknown(op))
            else $error("alu: opcode unknown while operands are driven");
      end
   end

endmodule

`default_nettype wire

// File: src/setCompare.sv
/*
   Set-compare unit
   - signed less-than and less-or-equal
   - equality and adder carry-out
*/
`default_nettype none

module setCompare (
   input  wire execPkg::wordT inA,
   input  wire execPkg::wordT inB,
   input  wire execPkg::wordT diff,
   input  wire                carry,
   input  wire                sl,
   input  wire                ltOnly,
   input  wire                seq,
   input  wire                sco,
   output execPkg::wordT      setOut
);
   import execPkg::*;

   localparam int msb = $bits(wordT) - 1;

   logic equal;
   logic lessThan;
   logic setBit;

   assign equal = (inA == inB);

   // Differing signs decide alone, matching signs cannot overflow A minus B
   assign lessThan = (inA[msb] != inB[msb]) ? inA[msb] : diff[msb];

   always_comb begin
      if (sco) begin
         setBit = carry;
      end else if (seq) begin
         setBit = equal;
      end else if (sl) begin
         setBit = ltOnly ? lessThan : (lessThan | equal);
      end else begin
         setBit = 1'b0;
      end
   end

   assign setOut = {{msb{1'b0}}, setBit};

   always_comb begin
      if (!$isunknown({sl, seq, sco})) begin
         assert final ($onehot0({sl, seq, sco}))
            else $error("setCompare: more than one set strobe active");
      end
   end

endmodule

`default_nettype wire

// File: src/branchResolve.sv
/*
   Branch and jump resolver
   - displacement sign extension and base selection
   - branch condition evaluation on Rs
   - next PC choice
*/
`default_nettype none

module branchResolve #(
   parameter int WIDTH = 16
) (
   input  wire execPkg::wordT pc,
   input  wire execPkg::wordT rs,
   input  wire execPkg::wordT immVal,
   input  wire isaPkg::instrT instr,
   input  wire                jump,
   input  wire                jumpReg,
   input  wire                branch,
   output execPkg::wordT      nextPc
);
   import isaPkg::*;
   import execPkg::*;

   localparam int w = $bits(wordT);

   wordT   disp;
   wordT   base;
   wordT   target;
   brCondT cond;
   logic   condMet;
   logic   taken;

   always_comb begin
      if (jump && jumpReg) begin
         disp = {{(w-8){instr[7]}}, instr[7:0]};
      end else if (jump) begin
         disp = {{(w-11){instr[10]}}, instr[10:0]};
      end else if (branch) begin
         disp = {{(w-8){immVal[7]}}, immVal[7:0]};
      end else begin
         disp = '0;
      end
   end

   // Register-indirect jumps are relative to Rs
   assign base = (jump && jumpReg) ? rs : pc;

   claAdder #(
      .WIDTH(WIDTH)
   ) iTargetAdder (
      .a   (base),
      .b   (disp),
      .cin (1'b0),
      .sum (target),
      .cout()
   );

   assign cond = instr[12:11];

   always_comb begin
      case (cond)
         brEqz:   condMet = (rs == '0);
         brNez:   condMet = (rs != '0);
         brLtz:   condMet = rs[w-1];
         brGez:   condMet = ~rs[w-1];
         default: condMet = 1'b0;
      endcase
   end

   assign taken  = branch & condMet;
   assign nextPc = (jump || taken) ? target : pc;

   always_comb begin
      if (!$isunknown({jump, branch})) begin
         assert final (!(jump && branch))
            else $error("branchResolve: jump and branch both asserted");
      end
   end

endmodule

`default_nettype wire

// File: src/execute.sv
/*
   Execute stage top level
   - operand selection and ALU opcode derivation
   - bit reversal and result selection
   - execute/memory pipeline register
*/
`default_nettype none

module execute #(
   parameter int WIDTH = 16
) (
   input  wire                clk,
   input  wire                rstN,
   input  wire                inValid,
   input  wire isaPkg::instrT instr,
   input  wire execPkg::wordT regData1,
   input  wire execPkg::wordT regData2,
   input  wire execPkg::wordT immVal,
   input  wire execPkg::wordT pc,
   input  wire                aluSrc,
   input  wire                immPres,
   input  wire                ldOrSt,
   input  wire                slbi,
   input  wire                btr,
   input  wire                sl,
   input  wire                seq,
   input  wire                sco,
   input  wire                invA,
   input  wire                invB,
   input  wire                jump,
   input  wire                jumpReg,
   input  wire                branch,
   output logic               outValid,
   output execPkg::wordT      result,
   output execPkg::wordT      wrData,
   output execPkg::wordT      nextPc,
   output logic               zero,
   output logic               ofl
);
   import isaPkg::*;
   import execPkg::*;

   wordT  inA;
   wordT  inB;
   wordT  aluOut;
   wordT  addSum;
   wordT  setOut;
   wordT  reversed;
   wordT  resultNext;
   wordT  pcNext;
   aluOpT aluOp;
   logic  aluInvA;
   logic  aluInvB;
   logic  aluCout;
   logic  aluZero;
   logic  aluOfl;

   assign inA = slbi ? (regData1 << 8) : regData1;
   assign inB = aluSrc ? immVal : regData2;

   // Opcode field position depends on the instruction form
   always_comb begin
      if (sl) begin
         aluOp = opAdd;
      end else if (ldOrSt) begin
         aluOp = instr[15:13];
      end else if (immPres) begin
         aluOp = {~instr[13], instr[12:11]};
      end else begin
         aluOp = {instr[11], instr[1:0]};
      end
   end

   // Compares need A minus B while carry-out needs plain A plus B
   assign aluInvA = invA & ~(sl | sco);
   assign aluInvB = sl | (invB & ~sco);

   alu #(
      .WIDTH(WIDTH)
   ) iAlu (
      .inA   (inA),
      .inB   (inB),
      .op    (aluOp),
      .invA  (aluInvA),
      .invB  (aluInvB),
      .aluOut(aluOut),
      .addSum(addSum),
      .cout  (aluCout),
      .zero  (aluZero),
      .ofl   (aluOfl)
   );

   setCompare iSetCompare (
      .inA   (inA),
      .inB   (inB),
      .diff  (addSum),
      .carry (aluCout),
      .sl    (sl),
      .ltOnly(instr[11]),
      .seq   (seq),
      .sco   (sco),
      .setOut(setOut)
   );

   branchResolve #(
      .WIDTH(WIDTH)
   ) iBranchResolve (
      .pc     (pc),
      .rs     (regData1),
      .immVal (immVal),
      .instr  (instr),
      .jump   (jump),
      .jumpReg(jumpReg),
      .branch (branch),
      .nextPc (pcNext)
   );

   assign reversed = {<<{inA}};

   assign resultNext = (sl | seq | sco) ? setOut :
                       btr              ? reversed : aluOut;

   // Execute/memory register holds its payload on idle cycles
   always_ff @(posedge clk) begin
      if (!rstN) begin
         outValid <= 1'b0;
         result   <= '0;
         wrData   <= '0;
         nextPc   <= '0;
         zero     <= 1'b0;
         ofl      <= 1'b0;
      end else begin
         outValid <= inValid;
         if (inValid) begin
            result <= resultNext;
            wrData <= regData2;
            nextPc <= pcNext;
            zero   <= aluZero;
            ofl    <= aluOfl;
         end
      end
   end

   // Decode must hand over known control strobes with every valid operation
   property strobesKnown;
      @(posedge clk) disable iff (!rstN)
         inValid |-> !$isunknown({aluSrc, immPres, ldOrSt, slbi, btr, sl, seq, sco,
                                  invA, invB, jump, jumpReg, branch});
   endproperty

   assert property (strobesKnown)
      else $error("execute: control strobe unknown on a valid operation");

endmodule

`default_nettype wire

// File: testbench/executeTb.sv
/*
   Testbench for the execute stage
   - clock, reset and watchdog
   - behavioural model of the stage
   - directed tests with word and flag compare tasks
*/
`default_nettype none

module executeTb;
   import isaPkg::*;
   import execPkg::*;

   localparam int clkPeriod   = 4;
   localparam int resetCycles = 8;
   localparam int opCount     = 140;

   logic   clk = 1'b0;
   logic   rstN;
   logic   inValid;
   instrT  instr;
   wordT   regData1;
   wordT   regData2;
   wordT   immVal;
   wordT   pc;
   logic   aluSrc;
   logic   immPres;
   logic   ldOrSt;
   logic   slbi;
   logic   btr;
   logic   sl;
   logic   seq;
   logic   sco;
   logic   invA;
   logic   invB;
   logic   jump;
   logic   jumpReg;
   logic   branch;
   logic   outValid;
   wordT   result;
   wordT   wrData;
   wordT   nextPc;
   logic   zero;
   logic   ofl;

   logic   expValid;
   wordT   expResult;
   wordT   expWrData;
   wordT   expNextPc;
   logic   expZero;
   logic   expOfl;
   integer seed = 32'hb0d9_7d63;

   execute #(.WIDTH(16)) i_execute (.*);

   initial begin
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Every operation gets four cycles of slack
   initial begin
      #((opCount * 4 + resetCycles) * clkPeriod);
      $display("Result: FAILED");
      $fatal(1, "Timeout: the tests did not finish in the expected time");
   end

   function automatic wordT randWord();
      return wordT'($random(seed));
   endfunction

   function automatic wordT rotLeft(wordT v, shamtT n);
      wordT r;
      r = v;
      for (int i = 0; i < int'(n); i++) begin
         r = {r[14:0], r[15]};
      end
      return r;
   endfunction

   function automatic wordT rotRight(wordT v, shamtT n);
      wordT r;
      r = v;
      for (int i = 0; i < int'(n); i++) begin
         r = {r[0], r[15:1]};
      end
      return r;
   endfunction

   function automatic wordT reverseBits(wordT v);
      wordT r;
      for (int i = 0; i < 16; i++) begin
         r[i] = v[15 - i];
      end
      return r;
   endfunction

   function automatic wordT signExtend(wordT v, int bits);
      wordT r;
      r = v;
      for (int i = bits; i < 16; i++) begin
         r[i] = v[bits - 1];
      end
      return r;
   endfunction

   // Reference model of the stage applied to the inputs as driven
   task automatic predict();
      wordT        a;
      wordT        b;
      wordT        opA;
      wordT        opB;
      wordT        aluRes;
      wordT        setRes;
      wordT        target;
      aluOpT       op;
      logic        effInvA;
      logic        effInvB;
      logic        carryIn;
      logic        taken;
      logic [16:0] wide;
      int          sumS;

      a = slbi ? {regData1[7:0], 8'h00} : regData1;
      b = aluSrc ? immVal : regData2;
      if (sl) begin
         op = opAdd;
      end else if (ldOrSt) begin
         op = instr[15:13];
      end else if (immPres) begin
         op = {~instr[13], instr[12:11]};
      end else begin
         op = {instr[11], instr[1:0]};
      end
      // Compares subtract while carry-out adds plain operands
      effInvA = invA && !sl && !sco;
      effInvB = sl || (invB && !sco);
      carryIn = effInvA || effInvB;
      opA = effInvA ? ~a : a;
      opB = effInvB ? ~b : b;
      case (op)
         opRll:   aluRes = rotLeft(opA, opB[3:0]);
         opSll:   aluRes = opA << opB[3:0];
         opRor:   aluRes = rotRight(opA, opB[3:0]);
         opSrl:   aluRes = opA >> opB[3:0];
         opAdd:   aluRes = opA + opB + {15'd0, carryIn};
         opOr:    aluRes = opA | opB;
         opXor:   aluRes = opA ^ opB;
         default: aluRes = opA & opB;
      endcase
      sumS = int'($signed(opA)) + int'($signed(opB));
      if (carryIn) begin
         sumS = sumS + 1;
      end
      wide = {1'b0, a} + {1'b0, b};
      if (sco) begin
         setRes = {15'd0, wide[16]};
      end else if (seq) begin
         setRes = {15'd0, a == b};
      end else if (instr[11]) begin
         setRes = {15'd0, $signed(a) < $signed(b)};
      end else begin
         setRes = {15'd0, $signed(a) <= $signed(b)};
      end
      if (jump && jumpReg) begin
         target = regData1 + signExtend(instr, 8);
      end else if (jump) begin
         target = pc + signExtend(instr, 11);
      end else begin
         target = pc + signExtend(immVal, 8);
      end
      case (instr[12:11])
         brEqz:   taken = (regData1 == '0);
         brNez:   taken = (regData1 != '0);
         brLtz:   taken = regData1[15];
         default: taken = !regData1[15];
      endcase
      expValid = inValid;
      if (inValid) begin
         if (sl || seq || sco) begin
            expResult = setRes;
         end else if (btr) begin
            expResult = reverseBits(a);
         end else begin
            expResult = aluRes;
         end
         expWrData = regData2;
         expNextPc = (jump || (branch && taken)) ? target : pc;
         expZero   = (aluRes == '0);
         expOfl    = (sumS > 32767) || (sumS < -32768);
      end
   endtask

   task automatic checkWord(string name, wordT got, wordT exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic checkFlag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic checkOutputs();
      checkFlag("outValid", outValid, expValid);
      checkWord("result", result, expResult);
      checkWord("wrData", wrData, expWrData);
      checkWord("nextPc", nextPc, expNextPc);
      checkFlag("zero", zero, expZero);
      checkFlag("ofl", ofl, expOfl);
   endtask

   task automatic clearStrobes();
      {aluSrc, immPres, ldOrSt, slbi, btr, sl, seq, sco} = '0;
      {invA, invB, jump, jumpReg, branch} = '0;
      instr = '0;
   endtask

   task automatic randomOperands();
      regData1 = randWord();
      regData2 = randWord();
      immVal   = randWord();
      pc       = randWord();
   endtask

   // Drives at a falling edge and expects the result at the next one
   task automatic execOp();
      inValid = 1'b1;
      predict();
      @(negedge clk);
      checkOutputs();
   endtask

   task automatic idleCycle();
      inValid  = 1'b0;
      expValid = 1'b0;
      @(negedge clk);
      checkOutputs();
   endtask

   task automatic addPair(wordT a, wordT b, logic sub);
      clearStrobes();
      instr    = 16'h0800;
      regData1 = a;
      regData2 = b;
      invB     = sub;
      execOp();
   endtask

   task automatic setPair(int kind, wordT a, wordT b);
      clearStrobes();
      regData1 = a;
      regData2 = b;
      case (kind)
         0: begin
            sl        = 1'b1;
            instr[11] = 1'b1;
         end
         1:       sl  = 1'b1;
         2:       seq = 1'b1;
         default: sco = 1'b1;
      endcase
      execOp();
   endtask

   task automatic resetAndIdle();
      {expValid, expZero, expOfl} = '0;
      expResult = '0;
      expWrData = '0;
      expNextPc = '0;
      repeat (resetCycles) @(negedge clk);
      checkOutputs();
      rstN = 1'b1;
      @(negedge clk);
      checkOutputs();
   endtask

   task automatic aluOpsBothForms();
      aluOpT op;
      for (int k = 0; k < 8; k++) begin
         op = aluOpT'(k);
         repeat (3) begin
            clearStrobes();
            randomOperands();
            instr      = randWord();
            instr[11]  = op[2];
            instr[1:0] = op[1:0];
            execOp();
            // Immediate form keeps the opcode in bits 13 to 11
            clearStrobes();
            immPres      = 1'b1;
            aluSrc       = 1'b1;
            instr[13]    = ~op[2];
            instr[12:11] = op[1:0];
            execOp();
         end
      end
   endtask

   task automatic aluSpecialCases();
      repeat (4) begin
         addPair(randWord(), randWord(), 1'b1);
         invB = 1'b0;
         invA = 1'b1;
         execOp();
      end
      clearStrobes();
      slbi    = 1'b1;
      immPres = 1'b1;
      aluSrc  = 1'b1;
      instr   = 16'h0800;
      repeat (2) begin
         randomOperands();
         execOp();
      end
      clearStrobes();
      btr = 1'b1;
      repeat (2) begin
         randomOperands();
         execOp();
      end
      // Load form takes the opcode from bits 15 to 13
      clearStrobes();
      ldOrSt = 1'b1;
      aluSrc = 1'b1;
      instr  = 16'h8000;
      execOp();
      addPair(16'h5a5a, 16'h5a5a, 1'b1);
      addPair(16'h7fff, 16'h0001, 1'b0);
      addPair(16'h8000, 16'hffff, 1'b0);
      addPair(16'h8000, 16'h0001, 1'b1);
      addPair(16'h7fff, 16'hffff, 1'b1);
   endtask

   task automatic setCompareCases();
      for (int kind = 0; kind < 4; kind++) begin
         repeat (6) setPair(kind, randWord(), randWord());
         setPair(kind, 16'h8000, 16'h0001);
         setPair(kind, 16'h0001, 16'h8000);
         setPair(kind, 16'h8000, 16'h7fff);
         setPair(kind, 16'h7fff, 16'h8000);
         setPair(kind, 16'h8000, 16'h8000);
         setPair(kind, 16'hffff, 16'h0001);
      end
   endtask

   task automatic branchConditions();
      wordT rsVals [3];
      rsVals = '{16'h0000, 16'h1234, 16'hf00d};
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 3; r++) begin
            clearStrobes();
            randomOperands();
            branch       = 1'b1;
            instr        = randWord();
            instr[12:11] = c[1:0];
            regData1     = rsVals[r];
            immVal       = immVal | 16'h0080;
            execOp();
         end
      end
   endtask

   task automatic jumpTargets();
      for (int k = 0; k < 4; k++) begin
         clearStrobes();
         randomOperands();
         jump      = 1'b1;
         jumpReg   = k[1];
         instr     = randWord();
         instr[10] = k[0];
         instr[7]  = k[0];
         execOp();
      end
   endtask

   task automatic backToBackOps();
      repeat (4) addPair(randWord(), randWord(), 1'b0);
      idleCycle();
      addPair(randWord(), randWord(), 1'b1);
      idleCycle();
   endtask

   initial begin
      rstN    = 1'b0;
      inValid = 1'b0;
      regData1 = '0;
      regData2 = '0;
      immVal   = '0;
      pc       = '0;
      clearStrobes();
      resetAndIdle();
      aluOpsBothForms();
      aluSpecialCases();
      setCompareCases();
      branchConditions();
      jumpTargets();
      backToBackOps();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
src/isaPkg.sv
src/execPkg.sv
src/claAdder.sv
src/alu.sv
src/setCompare.sv
src/branchResolve.sv
src/execute.sv
testbench/executeTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module executeTb -o executeSim \
   && ./obj_dir/executeSim \
   || { echo "Simulation failed"; exit 1; }
